//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_hier_tb
FILELIST  ?= mem_hier.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- mem_hier.f
rtl/mem_hier_pkg.sv
rtl/l1_cache.sv
rtl/mem_arbiter.sv
rtl/cacheline_adaptor.sv
rtl/mem_hier_top.sv
testbench/burst_mem_model.sv
testbench/mem_hier_checker.sv
testbench/mem_hier_tb.sv

//--- rtl/cacheline_adaptor.sv
`default_nettype none
`timescale 1ns/1ns

module cacheline_adaptor
    import mem_hier_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  line_req_t  line_req_i,
    output line_rsp_t  line_rsp_o,
    output burst_req_t burst_req_o,
    input  burst_rsp_t burst_rsp_i
);

    localparam int CNT_W = $clog2(BEATS);

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_BUSY,    // beats in flight
        AD_DONE     // line resp
    } ad_state_t;

    ad_state_t state;

    logic [CNT_W-1:0]  beat_cnt;
    logic [LINE_W-1:0] line_buf;
    logic              last_beat;

    assign last_beat = burst_rsp_i.resp && (beat_cnt == CNT_W'(BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= AD_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                AD_IDLE: begin
                    beat_cnt <= '0;
                    if (line_req_i.read || line_req_i.write) begin
                        state <= AD_BUSY;
                    end
                end
                AD_BUSY: begin
                    if (burst_rsp_i.resp) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= AD_DONE;
                    end
                end
                default: state <= AD_IDLE;
            endcase
        end
    end

    // one shift register for both directions
    // read beats enter at the top, write slices leave at the bottom
    always_ff @(posedge clk) begin
        if (state == AD_IDLE) begin
            line_buf <= line_req_i.wdata;
        end else if (state == AD_BUSY && burst_rsp_i.resp) begin
            line_buf <= {burst_rsp_i.rdata, line_buf[LINE_W-1:BURST_W]};
        end
    end

    always_comb begin
        burst_req_o.read  = (state == AD_BUSY) && line_req_i.read;
        burst_req_o.write = (state == AD_BUSY) && line_req_i.write;
        burst_req_o.addr  = line_req_i.addr;            // held by the arbiter
        burst_req_o.wdata = line_buf[BURST_W-1:0];      // current beat
    end

    always_comb begin
        line_rsp_o.resp  = (state == AD_DONE);
        line_rsp_o.rdata = line_buf;
    end

endmodule

`default_nettype wire

//--- rtl/l1_cache.sv
`default_nettype none
`timescale 1ns/1ns

module l1_cache
    import mem_hier_pkg::*;
#(
    parameter int LOG2_SETS = 3
) (
    input  logic      clk,
    input  logic      rst,
    input  word_req_t cpu_req_i,
    output word_rsp_t cpu_rsp_o,
    output line_req_t mem_req_o,
    input  line_rsp_t mem_rsp_i
);

    localparam int SETS       = 1 << LOG2_SETS;
    localparam int TAG_W      = ADDR_W - LOG2_SETS - OFFSET_W;
    localparam int BYTE_SEL_W = $clog2(MASK_W);
    localparam int WSEL_W     = OFFSET_W - BYTE_SEL_W;  // word inside a line

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMP,     // tag compare, respond on hit
        ST_WB,      // dirty victim out
        ST_FILL     // new line in
    } state_t;

    state_t state, state_nxt;

    logic [TAG_W-1:0]  tag_arr  [SETS];
    logic [LINE_W-1:0] data_arr [SETS];
    logic [SETS-1:0]   valid_arr;
    logic [SETS-1:0]   dirty_arr;

    logic [LOG2_SETS-1:0] idx;
    logic [TAG_W-1:0]     tag;
    logic [WSEL_W-1:0]    word_sel;
    logic [LINE_W-1:0]    cur_line;
    logic [LINE_W-1:0]    merged_line;
    logic                 hit;
    logic                 store_hit;
    logic                 fill_done;

    // address split
    assign idx      = cpu_req_i.addr[OFFSET_W +: LOG2_SETS];
    assign tag      = cpu_req_i.addr[ADDR_W-1 -: TAG_W];
    assign word_sel = cpu_req_i.addr[BYTE_SEL_W +: WSEL_W];

    assign cur_line  = data_arr[idx];
    assign hit       = valid_arr[idx] && (tag_arr[idx] == tag);
    assign store_hit = (state == ST_CMP) && hit && cpu_req_i.write;
    assign fill_done = (state == ST_FILL) && mem_rsp_i.resp;

    // place masked store bytes at the selected word
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < MASK_W; b++) begin
            if (cpu_req_i.mask[b]) begin
                merged_line[word_sel*WORD_W + b*8 +: 8] = cpu_req_i.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (cpu_req_i.read || cpu_req_i.write) begin
                    state_nxt = ST_CMP;
                end
            end
            ST_CMP: begin
                if (hit) begin
                    state_nxt = ST_IDLE;
                end else if (valid_arr[idx] && dirty_arr[idx]) begin
                    state_nxt = ST_WB;      // evict first
                end else begin
                    state_nxt = ST_FILL;
                end
            end
            ST_WB: begin
                if (mem_rsp_i.resp) begin
                    state_nxt = ST_FILL;
                end
            end
            ST_FILL: begin
                if (mem_rsp_i.resp) begin
                    state_nxt = ST_CMP;     // replay as a hit
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (fill_done) begin
            valid_arr[idx] <= 1'b1;
            dirty_arr[idx] <= 1'b0;
        end else if (store_hit) begin
            dirty_arr[idx] <= 1'b1;
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (fill_done) begin
            data_arr[idx] <= mem_rsp_i.rdata;
            tag_arr[idx]  <= tag;
        end else if (store_hit) begin
            data_arr[idx] <= merged_line;
        end
    end

    // client response
    always_comb begin
        cpu_rsp_o.resp  = (state == ST_CMP) && hit;
        cpu_rsp_o.rdata = cur_line[word_sel*WORD_W +: WORD_W];
    end

    // line request towards the arbiter
    always_comb begin
        mem_req_o = '0;
        case (state)
            ST_WB: begin
                mem_req_o.write = 1'b1;
                mem_req_o.addr  = {tag_arr[idx], idx, {OFFSET_W{1'b0}}};   // victim line
                mem_req_o.wdata = cur_line;
            end
            ST_FILL: begin
                mem_req_o.read = 1'b1;
                mem_req_o.addr = {tag, idx, {OFFSET_W{1'b0}}};
            end
            default: mem_req_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module mem_arbiter
    import mem_hier_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  line_req_t i_req_i,
    output line_rsp_t i_rsp_o,
    input  line_req_t d_req_i,
    output line_rsp_t d_rsp_o,
    output line_req_t mem_req_o,
    input  line_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_I,
        GNT_D
    } grant_t;

    grant_t grant, grant_nxt;

    logic i_pending;
    logic d_pending;

    assign i_pending = i_req_i.read || i_req_i.write;
    assign d_pending = d_req_i.read || d_req_i.write;

    always_comb begin
        grant_nxt = grant;
        case (grant)
            GNT_IDLE: begin
                if (d_pending) begin
                    grant_nxt = GNT_D;      // data side first
                end else if (i_pending) begin
                    grant_nxt = GNT_I;
                end
            end
            GNT_I, GNT_D: begin
                if (mem_rsp_i.resp) begin
                    grant_nxt = GNT_IDLE;   // rechoose next cycle
                end
            end
            default: grant_nxt = GNT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= GNT_IDLE;
        end else begin
            grant <= grant_nxt;
        end
    end

    // request mux
    always_comb begin
        case (grant)
            GNT_I:   mem_req_o = i_req_i;
            GNT_D:   mem_req_o = d_req_i;
            default: mem_req_o = '0;
        endcase
    end

    // response goes back to the owner only
    always_comb begin
        i_rsp_o.rdata = mem_rsp_i.rdata;
        i_rsp_o.resp  = mem_rsp_i.resp && (grant == GNT_I);
        d_rsp_o.rdata = mem_rsp_i.rdata;
        d_rsp_o.resp  = mem_rsp_i.resp && (grant == GNT_D);
    end

endmodule

`default_nettype wire

//--- rtl/mem_hier_pkg.sv
`default_nettype none

package mem_hier_pkg;

    localparam int ADDR_W   = 32;   // byte address
    localparam int WORD_W   = 32;   // client word
    localparam int MASK_W   = 4;    // one enable per byte
    localparam int LINE_W   = 256;  // eight words
    localparam int BURST_W  = 64;   // external beat
    localparam int BEATS    = 4;    // beats per line
    localparam int OFFSET_W = 5;    // byte offset inside a line

    // client side, word wide
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        logic [WORD_W-1:0] wdata;
    } word_req_t;

    typedef struct packed {
        logic              resp;
        logic [WORD_W-1:0] rdata;
    } word_rsp_t;

    // cache to memory, one full line per transfer
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;    // line aligned
        logic [LINE_W-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic              resp;
        logic [LINE_W-1:0] rdata;
    } line_rsp_t;

    // external port, one beat per resp
    typedef struct packed {
        logic               read;
        logic               write;
        logic [ADDR_W-1:0]  addr;
        logic [BURST_W-1:0] wdata;
    } burst_req_t;

    typedef struct packed {
        logic               resp;
        logic [BURST_W-1:0] rdata;
    } burst_rsp_t;

endpackage

`default_nettype wire

//--- rtl/mem_hier_top.sv
`default_nettype none
`timescale 1ns/1ns

module mem_hier_top
    import mem_hier_pkg::*;
#(
    parameter int LOG2_SETS = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  word_req_t  imem_req_i,
    output word_rsp_t  imem_rsp_o,
    input  word_req_t  dmem_req_i,
    output word_rsp_t  dmem_rsp_o,
    output burst_req_t bmem_req_o,
    input  burst_rsp_t bmem_rsp_i
);

    line_req_t i_line_req;      // icache -> arbiter
    line_rsp_t i_line_rsp;      // icache <- arbiter
    line_req_t d_line_req;      // dcache -> arbiter
    line_rsp_t d_line_rsp;      // dcache <- arbiter
    line_req_t arb_line_req;    // arbiter -> adaptor
    line_rsp_t arb_line_rsp;    // arbiter <- adaptor

    l1_cache #(
        .LOG2_SETS (LOG2_SETS)
    ) icache0 (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (imem_req_i),
        .cpu_rsp_o (imem_rsp_o),
        .mem_req_o (i_line_req),
        .mem_rsp_i (i_line_rsp)
    );

    l1_cache #(
        .LOG2_SETS (LOG2_SETS)
    ) dcache0 (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (dmem_req_i),
        .cpu_rsp_o (dmem_rsp_o),
        .mem_req_o (d_line_req),
        .mem_rsp_i (d_line_rsp)
    );

    mem_arbiter arb0 (
        .clk       (clk),
        .rst       (rst),
        .i_req_i   (i_line_req),
        .i_rsp_o   (i_line_rsp),
        .d_req_i   (d_line_req),
        .d_rsp_o   (d_line_rsp),
        .mem_req_o (arb_line_req),
        .mem_rsp_i (arb_line_rsp)
    );

    cacheline_adaptor adapt0 (
        .clk         (clk),
        .rst         (rst),
        .line_req_i  (arb_line_req),
        .line_rsp_o  (arb_line_rsp),
        .burst_req_o (bmem_req_o),    // external port
        .burst_rsp_i (bmem_rsp_i)
    );

endmodule

`default_nettype wire

//--- testbench/burst_mem_model.sv
`default_nettype none
`timescale 1ns/1ns

module burst_mem_model
    import mem_hier_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  burst_req_t req_i,
    output burst_rsp_t rsp_o
);

    localparam int CNT_W = $clog2(BEATS);

    logic [31:0]       words [logic [29:0]];    // only written words are kept
    logic [CNT_W-1:0]  beat;
    logic [1:0]        gap_cnt;                 // idle cycles before the next beat
    logic [1:0]        gap_seq;
    logic [ADDR_W-1:0] beat_addr;

    assign beat_addr = {req_i.addr[ADDR_W-1:OFFSET_W], beat, 3'b000};

    // untouched words hold their word address xor a fixed pattern
    function automatic logic [31:0] read_word(input logic [ADDR_W-1:0] a);
        if (words.exists(a[31:2])) begin
            return words[a[31:2]];
        end
        return {2'b00, a[31:2]} ^ 32'h5a5a_0000;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rsp_o   <= '0;
            beat    <= '0;
            gap_cnt <= 2'd1;
            gap_seq <= '0;
        end else begin
            rsp_o.resp <= 1'b0;
            if ((req_i.read || req_i.write) && !rsp_o.resp) begin
                if (gap_cnt != 2'd0) begin
                    gap_cnt <= gap_cnt - 1'b1;
                end else begin
                    if (req_i.write) begin
                        words[beat_addr[31:2]]         = req_i.wdata[31:0];
                        words[beat_addr[31:2] + 30'd1] = req_i.wdata[63:32];
                    end
                    rsp_o.rdata <= {read_word(beat_addr + 32'd4), read_word(beat_addr)};
                    rsp_o.resp  <= 1'b1;
                    beat        <= beat + 1'b1;     // wraps after the last beat
                    gap_cnt     <= gap_seq;         // latency varies beat to beat
                    gap_seq     <= gap_seq + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/mem_hier_checker.sv
`default_nettype none
`timescale 1ns/1ns

module mem_hier_checker
    import mem_hier_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input word_rsp_t  imem_rsp_i,
    input word_rsp_t  dmem_rsp_i,
    input line_req_t  i_line_req_i,
    input line_rsp_t  i_line_rsp_i,
    input line_req_t  d_line_req_i,
    input line_rsp_t  d_line_rsp_i,
    input burst_req_t bmem_req_i,
    input burst_rsp_t bmem_rsp_i
);

    int unsigned fail_cnt = 0;      // failed assertions so far

    logic bmem_busy;
    logic i_line_busy;
    logic d_line_busy;

    assign bmem_busy   = bmem_req_i.read || bmem_req_i.write;
    assign i_line_busy = i_line_req_i.read || i_line_req_i.write;
    assign d_line_busy = d_line_req_i.read || d_line_req_i.write;

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !imem_rsp_i.resp && !dmem_rsp_i.resp && !bmem_busy) else begin
        $error("client resp or external request active after reset");
        fail_cnt++;
    end

    // each line response goes to exactly one waiting cache
    a_one_owner: assert property (@(posedge clk) disable iff (rst)
        !(i_line_rsp_i.resp && d_line_rsp_i.resp) &&
        (!i_line_rsp_i.resp || i_line_busy) &&
        (!d_line_rsp_i.resp || d_line_busy)) else begin
        $error("line response reached both caches or a cache that was not waiting");
        fail_cnt++;
    end

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        (imem_rsp_i.resp || dmem_rsp_i.resp) |=>
        !(imem_rsp_i.resp && $past(imem_rsp_i.resp)) &&
        !(dmem_rsp_i.resp && $past(dmem_rsp_i.resp))) else begin
        $error("client resp held high for more than one cycle");
        fail_cnt++;
    end

    a_bmem_hold: assert property (@(posedge clk) disable iff (rst)
        (bmem_busy && !bmem_rsp_i.resp) |=>
        bmem_busy && $stable(bmem_req_i.addr) && !(bmem_req_i.read && bmem_req_i.write))
        else begin
        $error("external request dropped or changed before its beat");
        fail_cnt++;
    end

endmodule

bind mem_hier_top mem_hier_checker chk0 (
    .clk          (clk),
    .rst          (rst),
    .imem_rsp_i   (imem_rsp_o),
    .dmem_rsp_i   (dmem_rsp_o),
    .i_line_req_i (i_line_req),
    .i_line_rsp_i (i_line_rsp),
    .d_line_req_i (d_line_req),
    .d_line_rsp_i (d_line_rsp),
    .bmem_req_i   (bmem_req_o),
    .bmem_rsp_i   (bmem_rsp_i)
);

`default_nettype wire

//--- testbench/mem_hier_tb.sv
`default_nettype none
`timescale 1ns/1ns

module mem_hier_tb
    import mem_hier_pkg::*;
();

    localparam int          LOG2_SETS = 3;
    localparam logic [31:0] STRIDE    = 32'(1 << (LOG2_SETS + OFFSET_W));   // same set
    localparam int          TIMEOUT   = 400;
    localparam int          NUM_OPS   = 16;

    typedef struct packed {
        logic        dside;     // 1 for the data port
        logic        write;
        logic [31:0] addr;
        logic [3:0]  mask;
        logic [31:0] data;
        logic        chk;
        logic        hit;       // expects hit latency
        logic        pair;      // issued in the same cycle as the next entry
    } op_t;

    localparam op_t OPS_TBL [NUM_OPS] = '{
        '{1'b0, 1'b0, 32'h0000_0040, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1040, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0},
        '{1'b1, 1'b1, 32'h0000_1044, 4'h5, 32'hdead_beef, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1044, 4'h0, 32'h0000_0000, 1'b1, 1'b1, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1048, 4'h0, 32'h0000_0000, 1'b1, 1'b1, 1'b0},
        '{1'b0, 1'b1, 32'h0000_0080, 4'hf, 32'h1234_5678, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0080, 4'h0, 32'h0000_0000, 1'b1, 1'b1, 1'b0},
        '{1'b1, 1'b1, 32'h0000_1100, 4'hf, 32'hcafe_f00d, 1'b0, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1200, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0},  // evicts 1100
        '{1'b1, 1'b0, 32'h0000_1100, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0500, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b1},
        '{1'b1, 1'b0, 32'h0000_1500, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0180, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b1},  // dirty victim
        '{1'b1, 1'b1, 32'h0000_1600, 4'h9, 32'h0bad_f00d, 1'b0, 1'b0, 1'b0},
        '{1'b0, 1'b0, 32'h0000_0080, 4'h0, 32'h0000_0000, 1'b1, 1'b0, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1600, 4'h0, 32'h0000_0000, 1'b1, 1'b1, 1'b0}
    };

    logic        clk;
    logic        rst;
    word_req_t   ireq;
    word_req_t   dreq;
    word_rsp_t   irsp;
    word_rsp_t   drsp;
    burst_req_t  bmem_req;
    burst_rsp_t  bmem_rsp;
    logic [31:0] shadow [logic [29:0]];
    logic [31:0] seed;
    int          errors;
    int          timeouts;

    mem_hier_top #(
        .LOG2_SETS (LOG2_SETS)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .imem_req_i (ireq),
        .imem_rsp_o (irsp),
        .dmem_req_i (dreq),
        .dmem_rsp_o (drsp),
        .bmem_req_o (bmem_req),
        .bmem_rsp_i (bmem_rsp)
    );

    burst_mem_model mem0 (
        .clk   (clk),
        .rst   (rst),
        .req_i (bmem_req),
        .rsp_o (bmem_rsp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return {2'b00, addr[31:2]} ^ 32'h5a5a_0000;     // initial memory pattern
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [3:0] mask,
                                input logic [31:0] data);
        logic [31:0] w;
        w = shadow_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow[addr[31:2]] = w;
    endtask

    // four tags over two sets, eight words per line
    function automatic op_t rand_op(input logic [31:0] r);
        op_t o;
        o.dside = r[31];
        o.write = r[30];
        o.addr  = (r[31] ? 32'h0000_1400 : 32'h0000_0400) + 32'(r[21:20]) * STRIDE
                + 32'(r[16]) * 32'd32 + {27'd0, r[12:10], 2'b00};
        o.mask  = (r[7:4] == 4'h0) ? 4'hf : r[7:4];
        o.data  = {r[15:0], r[31:16]} ^ 32'h3c3c_0f0f;
        o.chk   = 1'b1;
        o.hit   = 1'b0;
        o.pair  = 1'b0;
        return o;
    endfunction

    task automatic drive_port(input op_t o);
        word_req_t q;
        q.read  = !o.write;
        q.write = o.write;
        q.addr  = o.addr;
        q.mask  = o.write ? o.mask : 4'h0;
        q.wdata = o.write ? o.data : 32'h0;
        if (o.dside) begin
            dreq = q;
        end else begin
            ireq = q;
        end
    endtask

    task automatic release_port(input logic dside);
        if (dside) begin
            dreq = '0;
        end else begin
            ireq = '0;
        end
    endtask

    task automatic finish_op(input op_t o, input logic [31:0] rdata, input int lat);
        logic [31:0] want;
        if (o.write) begin
            shadow_write(o.addr, o.mask, o.data);
        end else if (o.chk) begin
            want = shadow_read(o.addr);
            assert (rdata === want) else begin
                $display("Mismatch at %0t: %s read of %h returned %h, expected %h", $time,
                         o.dside ? "data" : "instr", o.addr, rdata, want);
                errors++;
            end
        end
        if (o.hit) begin
            assert (lat == 1) else begin
                $display("Mismatch at %0t: hit at %h took %0d cycles, expected 1",
                         $time, o.addr, lat);
                errors++;
            end
        end
    endtask

    // one op, or two on different ports in the same cycle
    task automatic run_ops(input op_t a, input op_t b, input logic both);
        op_t       op [2];
        logic      busy [2];
        logic      seen [2];
        word_rsp_t rsp;
        int        cycles;
        op[0]   = a;
        op[1]   = b;
        busy[0] = 1'b1;
        busy[1] = both;
        seen[0] = 1'b0;
        seen[1] = 1'b0;
        drive_port(a);
        if (both) begin
            drive_port(b);
        end
        cycles = 0;
        while ((busy[0] || busy[1]) && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            for (int k = 0; k < 2; k++) begin
                rsp = op[k].dside ? drsp : irsp;
                if (seen[k]) begin
                    release_port(op[k].dside);     // cycle after resp
                    busy[k] = 1'b0;
                    seen[k] = 1'b0;
                end else if (busy[k] && rsp.resp) begin
                    finish_op(op[k], rsp.rdata, cycles);
                    seen[k] = 1'b1;
                end
            end
        end
        if (busy[0] || busy[1]) begin
            $display("Timeout: no cache response within %0d cycles at %0t", TIMEOUT, $time);
            timeouts++;
            ireq = '0;
            dreq = '0;
        end
    endtask

    initial begin
        int k;
        clk      = 1'b0;
        rst      = 1'b1;
        ireq     = '0;
        dreq     = '0;
        errors   = 0;
        timeouts = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        k = 0;
        while (k < NUM_OPS && timeouts == 0) begin
            if (OPS_TBL[k].pair) begin
                run_ops(OPS_TBL[k], OPS_TBL[k+1], 1'b1);
                k += 2;
            end else begin
                run_ops(OPS_TBL[k], OPS_TBL[k], 1'b0);
                k++;
            end
        end
        seed = 32'hae4c;
        for (int n = 0; n < 200 && timeouts == 0; n++) begin
            seed = lcg_next(seed);
            run_ops(rand_op(seed), OPS_TBL[0], 1'b0);
        end
        repeat (4) @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut0.chk0.fail_cnt);
        if (errors == 0 && timeouts == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
